// File: source/tlx_cmd_pkg.sv
// command field widths, data widths and the command payload record
// shared by the FIFOs, the arbiter, the data sequencer and the top level
package tlx_cmd_pkg;

  // ----------------------------------------
  // command fields
  // ----------------------------------------
  localparam int OPCODE_W = 8;
  localparam int EA_W     = 68;
  localparam int AFUTAG_W = 16;
  localparam int DL_W     = 2;
  localparam int PL_W     = 3;
  localparam int ACTAG_W  = 12;
  localparam int PASID_W  = 20;

  // accelerator write data and one TLX beat
  localparam int CDATA_W = 1024;
  localparam int BEAT_W  = 512;

  // dl code of a 128-byte write, two beats
  localparam logic [DL_W-1:0] DL_128B = 2'b10;

  // 129 bits, opcode in the top bits
  typedef struct packed
  {
    logic [OPCODE_W-1:0] opcode;
    logic [EA_W-1:0]     ea_or_obj;
    logic [AFUTAG_W-1:0] afutag;
    logic [DL_W-1:0]     dl;
    logic [PL_W-1:0]     pl;
    logic [ACTAG_W-1:0]  actag;
    logic [PASID_W-1:0]  pasid;
  } cmd_payload_t;

endpackage

// File: source/tlx_flow_pkg.sv
// queue sizing and credit limits of the command converter
// the FIFOs and the credit tracker take their constants from here
package tlx_flow_pkg;

  // per-channel FIFO
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = 5;

  // ready drops at half full
  localparam logic [FIFO_AW:0] READY_LIMIT = 6'd16;

  // credit counters
  localparam int CMD_CREDIT_W  = 4;
  localparam int DATA_CREDIT_W = 6;

  // grants stop at or below this command count
  localparam logic [CMD_CREDIT_W-1:0] CMD_CREDIT_RESERVE = 4'd3;
  // grants stop below this data count
  localparam logic [DATA_CREDIT_W-1:0] DATA_CREDIT_RESERVE = 6'd5;

endpackage

// File: source/cmd_fifo.sv
// synchronous show-ahead FIFO, payload type chosen per instance
// head is valid while not_empty; ready is a fill-level hint to the writer
// a push while full is dropped and sets the sticky overflow flag
module cmd_fifo
  import tlx_flow_pkg::*;
#(
  parameter type payload_t = logic
)
(
  input  logic     clk_tlx,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t head,
  output logic     not_empty,
  output logic     ready,
  output logic     overflow
);

  payload_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   fill;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full      = (fill == (FIFO_AW+1)'(FIFO_DEPTH));
  assign not_empty = (fill != '0);
  assign ready     = (fill < READY_LIMIT);
  assign head      = mem[rd_ptr];

  // entry is lost when full
  assign do_push = push && !full;
  assign do_pop  = pop && not_empty;

  always_ff @(posedge clk_tlx)
  begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

  // pointers wrap naturally at FIFO_DEPTH
  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      if (push && full)
        overflow <= 1'b1;
    end
  end

  // the reader only pops a head it has seen
  a_no_pop_when_empty: assert property (
    @(posedge clk_tlx) disable iff (!rst_n)
    pop |-> not_empty
  );

endmodule

// File: source/cmd_arbiter.sv
// alternating grant between the write and read command FIFOs
// one grant per cycle while credit allows, command leaves one cycle later
// from a registered output stage
module cmd_arbiter
  import tlx_cmd_pkg::*;
(
  input  logic             clk_tlx,
  input  logic             rst_n,
  input  logic             credit_ok,
  input  logic             wdata_busy,
  input  logic             wr_pending,
  input  cmd_payload_t     wr_head,
  input  logic             rd_pending,
  input  cmd_payload_t     rd_head,
  output logic             wr_grant,
  output logic             rd_grant,
  output logic [DL_W-1:0]  grant_dl,
  output logic             afu_tlx_cmd_valid,
  output cmd_payload_t     afu_tlx_cmd
);

  // crankshaft, low prefers write
  logic prefer_rd;
  logic wr_eligible;
  logic any_grant;

  // ----------------------------------------
  // grant selection
  // ----------------------------------------

  // write must wait out the second beat of the previous one
  assign wr_eligible = wr_pending && !wdata_busy;

  // preferred channel first, the other one if preferred has nothing
  assign wr_grant = credit_ok && wr_eligible && (!prefer_rd || !rd_pending);
  assign rd_grant = credit_ok && rd_pending && (prefer_rd || !wr_eligible);

  assign any_grant = wr_grant || rd_grant;

  // only looked at together with wr_grant
  assign grant_dl = wr_head.dl;

  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
      prefer_rd <= 1'b0;
    else if (any_grant)
      prefer_rd <= !prefer_rd;
  end

  // ----------------------------------------
  // output stage
  // ----------------------------------------
  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
      afu_tlx_cmd_valid <= 1'b0;
    else
      afu_tlx_cmd_valid <= any_grant;
  end

  always_ff @(posedge clk_tlx)
  begin
    if (any_grant)
      afu_tlx_cmd <= wr_grant ? wr_head : rd_head;
  end

  a_single_grant: assert property (
    @(posedge clk_tlx) disable iff (!rst_n)
    !(wr_grant && rd_grant)
  );

endmodule

// File: source/wdata_sequencer.sv
// turns the 1024-bit write data of a granted write into TLX beats
// lower half goes out the cycle after the grant, the upper half one
// cycle later for a 128-byte write; busy covers the gap in between
module wdata_sequencer
  import tlx_cmd_pkg::*;
(
  input  logic               clk_tlx,
  input  logic               rst_n,
  input  logic               wr_grant,
  input  logic [DL_W-1:0]    grant_dl,
  input  logic [CDATA_W-1:0] wdata_head,
  output logic               wdata_busy,
  output logic               afu_tlx_cdata_valid,
  output logic [BEAT_W-1:0]  afu_tlx_cdata_bus
);

  logic              upper_pending;
  logic [BEAT_W-1:0] upper_hold;

  // second beat still owed
  assign wdata_busy = upper_pending;

  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      afu_tlx_cdata_valid <= 1'b0;
      upper_pending       <= 1'b0;
    end
    else
    begin
      afu_tlx_cdata_valid <= wr_grant || upper_pending;
      upper_pending       <= wr_grant && (grant_dl == DL_128B);
    end
  end

  // beat data, upper half parked until its cycle
  always_ff @(posedge clk_tlx)
  begin
    if (wr_grant)
    begin
      afu_tlx_cdata_bus <= wdata_head[BEAT_W-1:0];
      upper_hold        <= wdata_head[CDATA_W-1:BEAT_W];
    end
    else if (upper_pending)
      afu_tlx_cdata_bus <= upper_hold;
  end

  // arbiter holds writes back while the upper beat is owed
  a_no_grant_when_busy: assert property (
    @(posedge clk_tlx) disable iff (!rst_n)
    wr_grant |-> !wdata_busy
  );

endmodule

// File: source/credit_tracker.sv
// command and data credit bookkeeping toward the transaction layer
// counters load the initial credits once after reset, then count
// returns up and issued commands or beats down
module credit_tracker
  import tlx_flow_pkg::*;
(
  input  logic                     clk_tlx,
  input  logic                     rst_n,
  input  logic                     tlx_afu_cmd_credit,
  input  logic                     tlx_afu_cmd_data_credit,
  input  logic [CMD_CREDIT_W-1:0]  tlx_afu_cmd_initial_credit,
  input  logic [DATA_CREDIT_W-1:0] tlx_afu_cmd_data_initial_credit,
  input  logic                     afu_tlx_cmd_valid,
  input  logic                     afu_tlx_cdata_valid,
  output logic                     credit_ok,
  output logic [1:0]               fir_command_credit
);

  logic                     loaded;
  logic [CMD_CREDIT_W-1:0]  cmd_cnt;
  logic [DATA_CREDIT_W-1:0] data_cnt;

  // ----------------------------------------
  // counters
  // ----------------------------------------
  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      loaded   <= 1'b0;
      cmd_cnt  <= '0;
      data_cnt <= '0;
    end
    else if (!loaded)
    begin
      loaded   <= 1'b1;
      cmd_cnt  <= tlx_afu_cmd_initial_credit;
      data_cnt <= tlx_afu_cmd_data_initial_credit;
    end
    else
    begin
      case ({tlx_afu_cmd_credit, afu_tlx_cmd_valid})
        2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
        2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
        default: cmd_cnt <= cmd_cnt;
      endcase
      case ({tlx_afu_cmd_data_credit, afu_tlx_cdata_valid})
        2'b10:   data_cnt <= data_cnt + 1'b1;
        2'b01:   data_cnt <= data_cnt - 1'b1;
        default: data_cnt <= data_cnt;
      endcase
    end
  end

  // ----------------------------------------
  // grant enable and faults
  // ----------------------------------------

  // one cycle behind the counts, reserves absorb that lag
  always_ff @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      credit_ok          <= 1'b0;
      fir_command_credit <= 2'b00;
    end
    else
    begin
      credit_ok <= (cmd_cnt > CMD_CREDIT_RESERVE) && (data_cnt >= DATA_CREDIT_RESERVE);
      if (afu_tlx_cmd_valid && (cmd_cnt == '0))
        fir_command_credit[1] <= 1'b1;
      if (afu_tlx_cdata_valid && (data_cnt == '0))
        fir_command_credit[0] <= 1'b1;
    end
  end

endmodule

// File: source/tlx_cmd_converter.sv
// accelerator to TLX command converter, top level
// write and read commands are queued per channel, granted alternately under
// credit control and sent with their write data beats
// fault outputs are sticky until reset
module tlx_cmd_converter
  import tlx_cmd_pkg::*;
  import tlx_flow_pkg::*;
(
  input  logic                     clk_tlx,
  input  logic                     rst_n,
  // accelerator write channel
  input  logic                     wr_cmd_valid,
  input  logic [OPCODE_W-1:0]      wr_cmd_opcode,
  input  logic [EA_W-1:0]          wr_cmd_ea_or_obj,
  input  logic [AFUTAG_W-1:0]      wr_cmd_afutag,
  input  logic [DL_W-1:0]          wr_cmd_dl,
  input  logic [PL_W-1:0]          wr_cmd_pl,
  input  logic [ACTAG_W-1:0]       wr_cmd_actag,
  input  logic [PASID_W-1:0]       wr_cmd_pasid,
  input  logic [CDATA_W-1:0]       wr_cdata_bus,
  output logic                     wr_cmd_ready,
  // accelerator read channel
  input  logic                     rd_cmd_valid,
  input  logic [OPCODE_W-1:0]      rd_cmd_opcode,
  input  logic [EA_W-1:0]          rd_cmd_ea_or_obj,
  input  logic [AFUTAG_W-1:0]      rd_cmd_afutag,
  input  logic [DL_W-1:0]          rd_cmd_dl,
  input  logic [PL_W-1:0]          rd_cmd_pl,
  input  logic [ACTAG_W-1:0]       rd_cmd_actag,
  input  logic [PASID_W-1:0]       rd_cmd_pasid,
  output logic                     rd_cmd_ready,
  // TLX command and data
  output logic                     afu_tlx_cmd_valid,
  output logic [OPCODE_W-1:0]      afu_tlx_cmd_opcode,
  output logic [EA_W-1:0]          afu_tlx_cmd_ea_or_obj,
  output logic [AFUTAG_W-1:0]      afu_tlx_cmd_afutag,
  output logic [DL_W-1:0]          afu_tlx_cmd_dl,
  output logic [PL_W-1:0]          afu_tlx_cmd_pl,
  output logic [ACTAG_W-1:0]       afu_tlx_cmd_actag,
  output logic [PASID_W-1:0]       afu_tlx_cmd_pasid,
  output logic                     afu_tlx_cdata_valid,
  output logic [BEAT_W-1:0]        afu_tlx_cdata_bus,
  // TLX credits
  input  logic                     tlx_afu_cmd_credit,
  input  logic                     tlx_afu_cmd_data_credit,
  input  logic [CMD_CREDIT_W-1:0]  tlx_afu_cmd_initial_credit,
  input  logic [DATA_CREDIT_W-1:0] tlx_afu_cmd_data_initial_credit,
  // faults
  output logic [1:0]               fir_fifo_overflow,
  output logic [1:0]               fir_command_credit
);

  cmd_payload_t       wr_cmd_in;
  cmd_payload_t       rd_cmd_in;
  cmd_payload_t       wr_head;
  cmd_payload_t       rd_head;
  cmd_payload_t       afu_tlx_cmd;
  logic [CDATA_W-1:0] wdata_head;
  logic               wr_not_empty;
  logic               rd_not_empty;
  logic               wdata_not_empty;
  logic               wdata_overflow;
  logic               wr_grant;
  logic               rd_grant;
  logic [DL_W-1:0]    grant_dl;
  logic               wdata_busy;
  logic               credit_ok;

  assign wr_cmd_in = {wr_cmd_opcode, wr_cmd_ea_or_obj, wr_cmd_afutag, wr_cmd_dl,
                      wr_cmd_pl, wr_cmd_actag, wr_cmd_pasid};
  assign rd_cmd_in = {rd_cmd_opcode, rd_cmd_ea_or_obj, rd_cmd_afutag, rd_cmd_dl,
                      rd_cmd_pl, rd_cmd_actag, rd_cmd_pasid};
  assign {afu_tlx_cmd_opcode, afu_tlx_cmd_ea_or_obj, afu_tlx_cmd_afutag, afu_tlx_cmd_dl,
          afu_tlx_cmd_pl, afu_tlx_cmd_actag, afu_tlx_cmd_pasid} = afu_tlx_cmd;

  // ----------------------------------------
  // channel FIFOs
  // ----------------------------------------
  cmd_fifo #(.payload_t(cmd_payload_t)) wr_cmd_fifo_inst (
    .clk_tlx   (clk_tlx),
    .rst_n     (rst_n),
    .push      (wr_cmd_valid),
    .din       (wr_cmd_in),
    .pop       (wr_grant),
    .head      (wr_head),
    .not_empty (wr_not_empty),
    .ready     (wr_cmd_ready),
    .overflow  (fir_fifo_overflow[0])
  );

  cmd_fifo #(.payload_t(cmd_payload_t)) rd_cmd_fifo_inst (
    .clk_tlx   (clk_tlx),
    .rst_n     (rst_n),
    .push      (rd_cmd_valid),
    .din       (rd_cmd_in),
    .pop       (rd_grant),
    .head      (rd_head),
    .not_empty (rd_not_empty),
    .ready     (rd_cmd_ready),
    .overflow  (fir_fifo_overflow[1])
  );

  // write data, filled and drained alongside the write command FIFO
  cmd_fifo #(.payload_t(logic [CDATA_W-1:0])) wdata_fifo_inst (
    .clk_tlx   (clk_tlx),
    .rst_n     (rst_n),
    .push      (wr_cmd_valid),
    .din       (wr_cdata_bus),
    .pop       (wr_grant),
    .head      (wdata_head),
    .not_empty (wdata_not_empty),
    .ready     (),
    .overflow  (wdata_overflow)
  );

  // ----------------------------------------
  // grant, data and credit
  // ----------------------------------------
  cmd_arbiter cmd_arbiter_inst (
    .clk_tlx           (clk_tlx),
    .rst_n             (rst_n),
    .credit_ok         (credit_ok),
    .wdata_busy        (wdata_busy),
    .wr_pending        (wr_not_empty),
    .wr_head           (wr_head),
    .rd_pending        (rd_not_empty),
    .rd_head           (rd_head),
    .wr_grant          (wr_grant),
    .rd_grant          (rd_grant),
    .grant_dl          (grant_dl),
    .afu_tlx_cmd_valid (afu_tlx_cmd_valid),
    .afu_tlx_cmd       (afu_tlx_cmd)
  );

  wdata_sequencer wdata_sequencer_inst (
    .clk_tlx             (clk_tlx),
    .rst_n               (rst_n),
    .wr_grant            (wr_grant),
    .grant_dl            (grant_dl),
    .wdata_head          (wdata_head),
    .wdata_busy          (wdata_busy),
    .afu_tlx_cdata_valid (afu_tlx_cdata_valid),
    .afu_tlx_cdata_bus   (afu_tlx_cdata_bus)
  );

  credit_tracker credit_tracker_inst (
    .clk_tlx                         (clk_tlx),
    .rst_n                           (rst_n),
    .tlx_afu_cmd_credit              (tlx_afu_cmd_credit),
    .tlx_afu_cmd_data_credit         (tlx_afu_cmd_data_credit),
    .tlx_afu_cmd_initial_credit      (tlx_afu_cmd_initial_credit),
    .tlx_afu_cmd_data_initial_credit (tlx_afu_cmd_data_initial_credit),
    .afu_tlx_cmd_valid               (afu_tlx_cmd_valid),
    .afu_tlx_cdata_valid             (afu_tlx_cdata_valid),
    .credit_ok                       (credit_ok),
    .fir_command_credit              (fir_command_credit)
  );

  // data FIFO tracks the write command FIFO entry for entry
  // and can only overflow together with it
  a_wdata_lockstep: assert property (
    @(posedge clk_tlx) disable iff (!rst_n)
    (wdata_not_empty == wr_not_empty) && (wdata_overflow == fir_fifo_overflow[0])
  );

endmodule

// File: dv/tlx_cmd_converter_tb.sv
// testbench for the TLX command converter
// resets the DUT before each test, pushes random commands and checks the
// TLX side against reference arrays with concurrent assertions
module tlx_cmd_converter_tb
  import tlx_cmd_pkg::*;
  import tlx_flow_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic clk_tlx = 1'b0;
  logic rst_n = 1'b0;
  logic wr_cmd_valid = 1'b0;
  logic rd_cmd_valid = 1'b0;
  cmd_payload_t wr_cmd = '0;
  cmd_payload_t rd_cmd = '0;
  logic [CDATA_W-1:0] wr_cdata_bus = '0;
  logic wr_cmd_ready, rd_cmd_ready;
  logic afu_tlx_cmd_valid, afu_tlx_cdata_valid;
  cmd_payload_t out_cmd;
  logic [BEAT_W-1:0] afu_tlx_cdata_bus;
  logic tlx_afu_cmd_credit = 1'b0;
  logic tlx_afu_cmd_data_credit = 1'b0;
  logic [CMD_CREDIT_W-1:0] cmd_init = '0;
  logic [DATA_CREDIT_W-1:0] data_init = '0;
  logic [1:0] fir_fifo_overflow, fir_command_credit;

  // reference data, indexed by push and output order
  cmd_payload_t wr_exp [64];
  cmd_payload_t rd_exp [64];
  logic [BEAT_W-1:0] beat_exp [128];
  logic [5:0] wr_in, wr_out, rd_in, rd_out;
  logic [6:0] beat_in, beat_rd;
  cmd_payload_t exp_cmd;
  int wr_pushed, out_total, returns_cnt, quiet_cnt;
  logic ret_req = 1'b0;
  logic echo_cmd = 1'b0;
  logic idle_check = 1'b0;
  logic hold_check = 1'b0;
  int test_id = 0;
  int err_cnt = 0;
  int test_cnt = 0;
  int fail_cnt = 0;
  integer seed = 16;

  always #2 clk_tlx = ~clk_tlx;

  tlx_cmd_converter tlx_cmd_converter_inst (
    .clk_tlx(clk_tlx), .rst_n(rst_n),
    .wr_cmd_valid(wr_cmd_valid), .wr_cmd_opcode(wr_cmd.opcode),
    .wr_cmd_ea_or_obj(wr_cmd.ea_or_obj), .wr_cmd_afutag(wr_cmd.afutag),
    .wr_cmd_dl(wr_cmd.dl), .wr_cmd_pl(wr_cmd.pl), .wr_cmd_actag(wr_cmd.actag),
    .wr_cmd_pasid(wr_cmd.pasid), .wr_cdata_bus(wr_cdata_bus), .wr_cmd_ready(wr_cmd_ready),
    .rd_cmd_valid(rd_cmd_valid), .rd_cmd_opcode(rd_cmd.opcode),
    .rd_cmd_ea_or_obj(rd_cmd.ea_or_obj), .rd_cmd_afutag(rd_cmd.afutag),
    .rd_cmd_dl(rd_cmd.dl), .rd_cmd_pl(rd_cmd.pl), .rd_cmd_actag(rd_cmd.actag),
    .rd_cmd_pasid(rd_cmd.pasid), .rd_cmd_ready(rd_cmd_ready),
    .afu_tlx_cmd_valid(afu_tlx_cmd_valid), .afu_tlx_cmd_opcode(out_cmd.opcode),
    .afu_tlx_cmd_ea_or_obj(out_cmd.ea_or_obj), .afu_tlx_cmd_afutag(out_cmd.afutag),
    .afu_tlx_cmd_dl(out_cmd.dl), .afu_tlx_cmd_pl(out_cmd.pl),
    .afu_tlx_cmd_actag(out_cmd.actag), .afu_tlx_cmd_pasid(out_cmd.pasid),
    .afu_tlx_cdata_valid(afu_tlx_cdata_valid), .afu_tlx_cdata_bus(afu_tlx_cdata_bus),
    .tlx_afu_cmd_credit(tlx_afu_cmd_credit),
    .tlx_afu_cmd_data_credit(tlx_afu_cmd_data_credit),
    .tlx_afu_cmd_initial_credit(cmd_init),
    .tlx_afu_cmd_data_initial_credit(data_init),
    .fir_fifo_overflow(fir_fifo_overflow), .fir_command_credit(fir_command_credit)
  );

  // ----------------------------------------
  // reference model bookkeeping
  // ----------------------------------------
  assign exp_cmd = out_cmd.afutag[15] ? rd_exp[rd_out] : wr_exp[wr_out];

  always @(posedge clk_tlx or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_in <= '0;
      wr_out <= '0;
      rd_in <= '0;
      rd_out <= '0;
      beat_in <= '0;
      beat_rd <= '0;
      wr_pushed <= 0;
      out_total <= 0;
      returns_cnt <= 0;
      quiet_cnt <= 0;
    end
    else
    begin
      if (wr_cmd_valid)
      begin
        wr_exp[wr_in] <= wr_cmd;
        wr_in <= wr_in + 6'd1;
        wr_pushed <= wr_pushed + 1;
        beat_exp[beat_in] <= wr_cdata_bus[BEAT_W-1:0];
        if (wr_cmd.dl == DL_128B)
        begin
          beat_exp[beat_in + 7'd1] <= wr_cdata_bus[CDATA_W-1:BEAT_W];
          beat_in <= beat_in + 7'd2;
        end
        else
          beat_in <= beat_in + 7'd1;
      end
      if (rd_cmd_valid)
      begin
        rd_exp[rd_in] <= rd_cmd;
        rd_in <= rd_in + 6'd1;
      end
      if (afu_tlx_cmd_valid && out_cmd.afutag[15])
        rd_out <= rd_out + 6'd1;
      else if (afu_tlx_cmd_valid)
        wr_out <= wr_out + 6'd1;
      if (afu_tlx_cmd_valid)
        out_total <= out_total + 1;
      if (afu_tlx_cdata_valid)
        beat_rd <= beat_rd + 7'd1;
      if (tlx_afu_cmd_credit)
        returns_cnt <= returns_cnt + 1;
      quiet_cnt <= afu_tlx_cmd_valid ? 0 : quiet_cnt + 1;
    end
  end

  // transaction layer side, data credits always come back
  always @(posedge clk_tlx)
  begin
    tlx_afu_cmd_credit <= ret_req || (echo_cmd && afu_tlx_cmd_valid);
    tlx_afu_cmd_data_credit <= afu_tlx_cdata_valid;
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_idle: assert property (@(posedge clk_tlx) idle_check |-> !afu_tlx_cmd_valid &&
    !afu_tlx_cdata_valid && fir_fifo_overflow == 2'b00 && wr_cmd_ready && rd_cmd_ready)
  else
  begin
    $display("CHECK FAILED idle state valid %h/%h ready %h/%h fir_fifo_overflow %h",
      afu_tlx_cmd_valid, afu_tlx_cdata_valid, wr_cmd_ready, rd_cmd_ready,
      fir_fifo_overflow);
    err_cnt++;
  end

  a_cmd_fields: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    afu_tlx_cmd_valid |-> out_cmd == exp_cmd)
  else
  begin
    $display("CHECK FAILED afu_tlx_cmd exp %h got %h", exp_cmd, out_cmd);
    err_cnt++;
  end

  a_beat_data: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    afu_tlx_cdata_valid |-> afu_tlx_cdata_bus == beat_exp[beat_rd])
  else
  begin
    $display("CHECK FAILED afu_tlx_cdata_bus exp %h got %h", beat_exp[beat_rd],
      afu_tlx_cdata_bus);
    err_cnt++;
  end

  // lower half with the write command, upper half one cycle later
  a_first_beat: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    afu_tlx_cmd_valid && !out_cmd.afutag[15] |-> afu_tlx_cdata_valid)
  else
  begin
    $display("CHECK FAILED afu_tlx_cdata_valid exp 1 got %h", afu_tlx_cdata_valid);
    err_cnt++;
  end

  a_second_beat: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    afu_tlx_cmd_valid && !out_cmd.afutag[15] && out_cmd.dl == DL_128B
    |=> afu_tlx_cdata_valid)
  else
  begin
    $display("CHECK FAILED afu_tlx_cdata_valid exp 1 got %h", afu_tlx_cdata_valid);
    err_cnt++;
  end

  a_alternate: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    test_id == 3 && afu_tlx_cmd_valid |-> out_cmd.afutag[15] == out_total[0])
  else
  begin
    $display("CHECK FAILED afu_tlx_cmd_afutag exp bit15 %h got %h", out_total[0],
      out_cmd.afutag);
    err_cnt++;
  end

  a_credit_limit: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    out_total <= int'(cmd_init) + returns_cnt && fir_command_credit == 2'b00)
  else
  begin
    $display("CHECK FAILED fir_command_credit %h, issued %h against credit %h",
      fir_command_credit, out_total, int'(cmd_init) + returns_cnt);
    err_cnt++;
  end

  a_output_stopped: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    hold_check |-> !afu_tlx_cmd_valid && out_total < 12)
  else
  begin
    $display("commands kept leaving after credit returns stopped");
    err_cnt++;
  end

  a_ready_level: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    test_id == 5 |-> wr_cmd_ready == (wr_pushed < int'(READY_LIMIT)))
  else
  begin
    $display("CHECK FAILED wr_cmd_ready got %h with %h writes queued", wr_cmd_ready,
      wr_pushed);
    err_cnt++;
  end

  a_overflow: assert property (@(posedge clk_tlx) disable iff (!rst_n)
    test_id == 5 && wr_pushed > FIFO_DEPTH |-> fir_fifo_overflow == 2'b01)
  else
  begin
    $display("CHECK FAILED fir_fifo_overflow exp 1 got %h", fir_fifo_overflow);
    err_cnt++;
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic start_test(input int id, input int cmd_credit, input logic echo);
    test_id = 0;
    rst_n <= 1'b0;
    wr_cmd_valid <= 1'b0;
    rd_cmd_valid <= 1'b0;
    cmd_init <= CMD_CREDIT_W'(cmd_credit);
    data_init <= '1;
    echo_cmd <= echo;
    repeat (3) @(posedge clk_tlx);
    rst_n <= 1'b1;
    @(posedge clk_tlx);
    test_id = id;
  endtask

  function automatic cmd_payload_t random_cmd(input logic is_rd, input logic two_beat);
    cmd_payload_t c;
    logic [31:0] r0, r1, r2;
    r0 = $random(seed);
    r1 = $random(seed);
    r2 = $random(seed);
    c.opcode = r0[7:0];
    c.ea_or_obj = {r0[31:28], r1, r2};
    c.afutag = {is_rd, r0[22:8]};
    c.dl = two_beat ? DL_128B : 2'b01;
    c.pl = r0[25:23];
    c.actag = r1[11:0];
    c.pasid = r2[19:0];
    return c;
  endfunction

  // mix picks the write length at random, otherwise 64 bytes
  task automatic push_cmds(input int n_wr, input int n_rd, input logic mix);
    logic [CDATA_W-1:0] data;
    logic [31:0] r;
    int i;
    for (i = 0; i < n_wr || i < n_rd; i++)
    begin
      for (int w = 0; w < CDATA_W / 32; w++)
        data[w*32 +: 32] = $random(seed);
      r = $random(seed);
      @(posedge clk_tlx);
      wr_cmd_valid <= (i < n_wr);
      rd_cmd_valid <= (i < n_rd);
      wr_cmd <= random_cmd(1'b0, mix && r[4]);
      rd_cmd <= random_cmd(1'b1, 1'b0);
      wr_cdata_bus <= data;
    end
    @(posedge clk_tlx);
    wr_cmd_valid <= 1'b0;
    rd_cmd_valid <= 1'b0;
  endtask

  task automatic return_credit();
    @(posedge clk_tlx);
    ret_req <= 1'b1;
    @(posedge clk_tlx);
    ret_req <= 1'b0;
  endtask

  task automatic end_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("tests failed");
    $finish;
  endtask

  task automatic wait_drained(input int target);
    int n;
    n = 0;
    while (out_total < target || beat_rd != beat_in)
    begin
      @(posedge clk_tlx);
      n++;
      if (n > 500)
        end_on_timeout("commands and data beats to leave");
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before)
      $display("test %0d %s: pass", test_cnt, name);
    else
    begin
      fail_cnt++;
      $display("test %0d %s: FAIL, %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial
  begin
    int e;
    int n;
    e = err_cnt;
    start_test(1, 15, 1'b1);
    idle_check <= 1'b1;
    repeat (2) @(posedge clk_tlx);
    idle_check <= 1'b0;
    report_test("reset state", e);

    e = err_cnt;
    start_test(2, 15, 1'b1);
    push_cmds(10, 10, 1'b1);
    wait_drained(20);
    report_test("command and data path", e);

    e = err_cnt;
    start_test(3, 3, 1'b1);
    push_cmds(4, 4, 1'b0);
    return_credit();
    wait_drained(8);
    report_test("alternation", e);

    e = err_cnt;
    start_test(4, 6, 1'b0);
    push_cmds(6, 6, 1'b0);
    return_credit();
    return_credit();
    n = 0;
    while (quiet_cnt < 8)
    begin
      @(posedge clk_tlx);
      n++;
      if (n > 200)
        end_on_timeout("command output to stop");
    end
    hold_check <= 1'b1;
    repeat (40) @(posedge clk_tlx);
    hold_check <= 1'b0;
    report_test("credit limit", e);

    e = err_cnt;
    start_test(5, 0, 1'b0);
    push_cmds(FIFO_DEPTH + 1, 0, 1'b0);
    // nothing drains, so the flag has to hold
    repeat (4) @(posedge clk_tlx);
    test_id = 0;
    report_test("back-pressure and overflow", e);

    $display("%0d tests run, %0d failed, %0d check errors", test_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: tlx_cmd_converter.f
source/tlx_cmd_pkg.sv
source/tlx_flow_pkg.sv
source/cmd_fifo.sv
source/cmd_arbiter.sv
source/wdata_sequencer.sv
source/credit_tracker.sv
source/tlx_cmd_converter.sv
dv/tlx_cmd_converter_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the converter testbench with Verilator.
# Exit status is nonzero when the build fails or the testbench reports failure.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --assert --timing \
  -f tlx_cmd_converter.f \
  --top-module tlx_cmd_converter_tb \
  -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

"./$BUILD_DIR/Vtlx_cmd_converter_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
